/* div_types_pkg.sv */
/*
 * Divider arithmetic formats
 * Operand and result words of the pipelined unsigned divider,
 * together with the width constants they are built from.
 */

package div_types_pkg;

	// ------------------------------
	// widths
	// ------------------------------

	// operand width, also the number of quotient bits
	localparam int data_width = 16;

	// tag travels with each operation unchanged
	localparam int tag_width = 8;

	// ------------------------------
	// slave side word
	// ------------------------------

	// one operand pair plus its tag
	typedef struct packed {
		logic [data_width-1:0] dividend;
		logic [data_width-1:0] divisor;
		logic [tag_width-1:0]  tag;
	} div_operands_t;

	// ------------------------------
	// master side word
	// ------------------------------

	// divide by zero gives all ones and remainder == dividend
	typedef struct packed {
		logic [data_width-1:0] quotient;
		logic [data_width-1:0] remainder;
		logic [tag_width-1:0]  tag;
	} div_result_t;

endpackage

/* pipe_pkg.sv */
/*
 * Divider pipeline formats
 * Stage count and the state word handed from one
 * restoring-division stage to the next.
 */

package pipe_pkg;

	// one stage per quotient bit
	localparam int pipeline_stages = div_types_pkg::data_width;

	// ------------------------------
	// per-stage state
	// ------------------------------

	// dividend field shifts left, its msb feeds the next step
	typedef struct packed {
		// partial remainder, always below the divisor
		logic [div_types_pkg::data_width-1:0] remainder;
		// dividend bits not consumed yet
		logic [div_types_pkg::data_width-1:0] dividend;
		logic [div_types_pkg::data_width-1:0] divisor;
		// quotient bits so far, newest in the lsb
		logic [div_types_pkg::data_width-1:0] quotient;
		logic [div_types_pkg::tag_width-1:0]  tag;
	} stage_state_t;

endpackage

/* pipeline_insert_ff.sv */
/*
 * Pipeline output skid buffer
 * Holding register on the slave side plus an optional output
 * register on the master side. Parks one item when the master
 * stalls and reports the next-cycle slave readiness so that the
 * pipeline controller can register its stage enables.
 */

`timescale 1ns/1ps

module pipeline_insert_ff #(
	parameter bit master_regs = 1'b1
) (
	input  logic                       reset,
	input  logic                       clk,

	// slave port
	input  div_types_pkg::div_result_t s_data,
	input  logic                       s_valid,
	output logic                       s_ready,

	// master port
	output div_types_pkg::div_result_t m_data,
	output logic                       m_valid,
	input  logic                       m_ready,

	// status
	output logic                       buffered,
	output logic                       s_ready_next
);

	// ------------------------------
	// slave side holding register
	// ------------------------------

	logic                       reg_hold_valid;
	logic                       next_hold_valid;
	div_types_pkg::div_result_t reg_hold_data;

	// internal link toward the output stage
	logic                       out_valid;
	logic                       out_ready;
	div_types_pkg::div_result_t out_data;

	// parked item goes first
	assign out_valid = reg_hold_valid | s_valid;
	assign out_data  = reg_hold_valid ? reg_hold_data : s_data;

	always_comb begin
		next_hold_valid = reg_hold_valid;
		if (reg_hold_valid) begin
			if (out_ready) begin
				next_hold_valid = 1'b0;
			end
		end else if (s_valid && !out_ready) begin
			// arriving item cannot move on, park it
			next_hold_valid = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			reg_hold_valid <= 1'b0;
		end else begin
			reg_hold_valid <= next_hold_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!reg_hold_valid && s_valid && !out_ready) begin
			reg_hold_data <= s_data;
		end
	end

	assign s_ready      = !reg_hold_valid;
	assign s_ready_next = !next_hold_valid;
	assign buffered     = reg_hold_valid;

	// ------------------------------
	// master side
	// ------------------------------

	generate
		if (master_regs) begin : g_out_reg
			logic                       reg_m_valid;
			div_types_pkg::div_result_t reg_m_data;

			// output register takes a new word when empty or drained
			assign out_ready = !reg_m_valid || m_ready;

			always_ff @(posedge clk) begin
				if (reset) begin
					reg_m_valid <= 1'b0;
				end else if (out_ready) begin
					reg_m_valid <= out_valid;
				end
			end

			always_ff @(posedge clk) begin
				if (out_ready && out_valid) begin
					reg_m_data <= out_data;
				end
			end

			assign m_valid = reg_m_valid;
			assign m_data  = reg_m_data;
		end else begin : g_out_comb
			// straight through while nothing is parked
			assign out_ready = m_ready;
			assign m_valid   = out_valid;
			assign m_data    = out_data;
		end
	endgenerate

endmodule

/* pipeline_control.sv */
/*
 * Stage-enable pipeline controller
 * Builds the backward chain of stage enables from sink readiness
 * and stage occupancy, registers it with the slave ready, keeps
 * one valid bit per stage and drives the master port through the
 * output skid buffer.
 */

`timescale 1ns/1ps

module pipeline_control #(
	parameter bit master_regs = 1'b1
) (
	input  logic                                  reset,
	input  logic                                  clk,

	// slave port
	input  div_types_pkg::div_operands_t          s_data,
	input  logic                                  s_valid,
	output logic                                  s_ready,

	// master port
	output div_types_pkg::div_result_t            m_data,
	output logic                                  m_valid,
	input  logic                                  m_ready,

	// stage side
	output logic [pipe_pkg::pipeline_stages-1:0]  stage_cke,
	output logic [pipe_pkg::pipeline_stages-1:0]  stage_valid,
	input  logic [pipe_pkg::pipeline_stages-1:0]  next_valid,
	output div_types_pkg::div_operands_t          src_data,
	output logic                                  src_valid,
	input  div_types_pkg::div_result_t            sink_data,
	output logic                                  buffered
);

	localparam int last_stage = pipe_pkg::pipeline_stages - 1;

	logic                                 sink_ready_next;
	logic [pipe_pkg::pipeline_stages-1:0] next_cke;
	logic [pipe_pkg::pipeline_stages-1:0] reg_cke;
	logic [pipe_pkg::pipeline_stages-1:0] reg_valid;
	logic                                 reg_s_ready;

	// ------------------------------
	// enable chain
	// ------------------------------

	// a stage may load if its successor moves or it is idle
	always_comb begin
		next_cke[last_stage] = sink_ready_next
			|| (!reg_valid[last_stage] && !next_valid[last_stage]);
		for (int i = last_stage - 1; i >= 0; i--) begin
			next_cke[i] = next_cke[i+1] || (!reg_valid[i] && !next_valid[i]);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			reg_cke     <= '1;
			reg_s_ready <= 1'b1;
		end else begin
			reg_cke     <= next_cke;
			reg_s_ready <= next_cke[0];
		end
	end

	// ------------------------------
	// stage occupancy
	// ------------------------------

	always_ff @(posedge clk) begin
		if (reset) begin
			reg_valid <= '0;
		end else begin
			for (int i = 0; i <= last_stage; i++) begin
				if (reg_cke[i]) begin
					reg_valid[i] <= next_valid[i];
				end
			end
		end
	end

	// last stage enable already follows the sink readiness
	pipeline_insert_ff #(
		.master_regs  (master_regs)
	) i_pipeline_insert_ff (
		.reset        (reset),
		.clk          (clk),
		.s_data       (sink_data),
		.s_valid      (reg_valid[last_stage]),
		.s_ready      (),
		.m_data       (m_data),
		.m_valid      (m_valid),
		.m_ready      (m_ready),
		.buffered     (buffered),
		.s_ready_next (sink_ready_next)
	);

	assign s_ready     = reg_s_ready;
	assign stage_cke   = reg_cke;
	assign stage_valid = reg_valid;
	assign src_data    = s_data;
	assign src_valid   = s_valid;

endmodule

/* div_stage.sv */
/*
 * Restoring division step
 * Shifts one dividend bit into the partial remainder, subtracts
 * the divisor when it fits and records one quotient bit.
 */

`timescale 1ns/1ps

module div_stage (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   cke,
	input  pipe_pkg::stage_state_t state_in,
	output pipe_pkg::stage_state_t state_out
);

	localparam int w = div_types_pkg::data_width;

	logic [w:0]             trial;
	logic [w-1:0]           diff;
	logic                   fits;
	pipe_pkg::stage_state_t next_state;

	// remainder with the next dividend bit appended
	assign trial = {state_in.remainder, state_in.dividend[w-1]};
	assign fits  = trial >= {1'b0, state_in.divisor};
	// only taken when it fits, so the carry out is always zero
	assign diff  = trial[w-1:0] - state_in.divisor;

	always_comb begin
		next_state           = state_in;
		next_state.remainder = fits ? diff : trial[w-1:0];
		next_state.dividend  = {state_in.dividend[w-2:0], 1'b0};
		next_state.quotient  = {state_in.quotient[w-2:0], fits};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_out <= '0;
		end else if (cke) begin
			state_out <= next_state;
		end
	end

endmodule

/* pipelined_divider.sv */
/*
 * Pipelined 16-bit unsigned divider
 * Sixteen restoring-division stages, one quotient bit each, run
 * by a stage-enable controller. Operands and tag enter on a
 * valid/ready slave port; quotient, remainder and the same tag
 * leave on the master port through a skid buffer.
 */

`timescale 1ns/1ps

module pipelined_divider #(
	parameter bit master_regs = 1'b1
) (
	input  logic                         clk,
	input  logic                         reset,

	// operands in
	input  div_types_pkg::div_operands_t s_data,
	input  logic                         s_valid,
	output logic                         s_ready,

	// results out
	output div_types_pkg::div_result_t   m_data,
	output logic                         m_valid,
	input  logic                         m_ready
);

	localparam int stages = pipe_pkg::pipeline_stages;

	// ------------------------------
	// controller
	// ------------------------------

	logic [stages-1:0]            stage_cke;
	logic [stages-1:0]            stage_valid;
	logic [stages-1:0]            next_valid;
	div_types_pkg::div_operands_t src_data;
	logic                         src_valid;
	div_types_pkg::div_result_t   sink_data;

	// each stage sees what its predecessor holds
	assign next_valid = {stage_valid[stages-2:0], src_valid};

	pipeline_control #(
		.master_regs (master_regs)
	) i_pipeline_control (
		.reset       (reset),
		.clk         (clk),
		.s_data      (s_data),
		.s_valid     (s_valid),
		.s_ready     (s_ready),
		.m_data      (m_data),
		.m_valid     (m_valid),
		.m_ready     (m_ready),
		.stage_cke   (stage_cke),
		.stage_valid (stage_valid),
		.next_valid  (next_valid),
		.src_data    (src_data),
		.src_valid   (src_valid),
		.sink_data   (sink_data),
		.buffered    ()
	);

	// ------------------------------
	// divider stages
	// ------------------------------

	// entry 0 is the operand word, entry i+1 is stage i's register
	pipe_pkg::stage_state_t stage_state [0:stages];

	assign stage_state[0] = '{
		remainder: '0,
		dividend:  src_data.dividend,
		divisor:   src_data.divisor,
		quotient:  '0,
		tag:       src_data.tag
	};

	for (genvar i = 0; i < stages; i++) begin : g_stage
		div_stage i_div_stage (
			.clk       (clk),
			.reset     (reset),
			.cke       (stage_cke[i]),
			.state_in  (stage_state[i]),
			.state_out (stage_state[i+1])
		);
	end

	// last stage holds the finished quotient and remainder
	assign sink_data = '{
		quotient:  stage_state[stages].quotient,
		remainder: stage_state[stages].remainder,
		tag:       stage_state[stages].tag
	};

endmodule

/* tb_pipelined_divider.sv */
/*
 * Testbench for the pipelined divider
 * Drives operand pairs through the slave port, predicts each result
 * with a reference model and checks quotient, remainder and tag in
 * order on the master port, with and without back-pressure.
 */

`timescale 1ns/1ps

module tb_pipelined_divider;

	localparam int dw = div_types_pkg::data_width;
	localparam int tw = div_types_pkg::tag_width;
	localparam int clk_period = 4;
	// directed, divide by zero, burst, back-pressure, gaps, reset run
	localparam int total_ops = 5 + 6 + 500 + 500 + 300 + 25;
	localparam int watchdog_cycles = total_ops * 40 + 2000;

	logic                         clk;
	logic                         reset;
	div_types_pkg::div_operands_t s_data;
	logic                         s_valid;
	logic                         s_ready;
	div_types_pkg::div_result_t   m_data;
	logic                         m_valid;
	logic                         m_ready;

	div_types_pkg::div_result_t exp_q[$];
	integer                     seed;
	logic                       bp_on;
	logic                       saw_stall;
	logic [tw-1:0]              next_tag;
	int                         errors;
	int                         checks;
	int                         tests;
	int                         test_errors;
	int                         test_checks;

	pipelined_divider #(
		.master_regs (1'b1)
	) i_pipelined_divider (
		.clk     (clk),
		.reset   (reset),
		.s_data  (s_data),
		.s_valid (s_valid),
		.s_ready (s_ready),
		.m_data  (m_data),
		.m_valid (m_valid),
		.m_ready (m_ready)
	);

	always #2 clk = ~clk;

	// ------------------------------
	// reference model and helpers
	// ------------------------------

	// zero divisor gives all ones and the dividend back
	function automatic div_types_pkg::div_result_t expected_result(
		input logic [dw-1:0] dividend,
		input logic [dw-1:0] divisor,
		input logic [tw-1:0] tag
	);
		div_types_pkg::div_result_t res;
		if (divisor == '0) begin
			res.quotient  = '1;
			res.remainder = dividend;
		end else begin
			res.quotient  = dividend / divisor;
			res.remainder = dividend % divisor;
		end
		res.tag = tag;
		return res;
	endfunction

	function automatic logic [dw-1:0] random_word();
		integer r;
		r = $random(seed);
		return r[dw-1:0];
	endfunction

	task automatic check_field(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			$display("FAILED at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
			errors++;
		end
	endtask

	// one cycle; m_ready toggles at random under back-pressure
	task automatic tick();
		integer r;
		@(negedge clk);
		r = $random(seed);
		m_ready = bp_on ? r[0] : 1'b1;
	endtask

	task automatic send_op(input logic [dw-1:0] dividend, input logic [dw-1:0] divisor,
			input int gap);
		for (int i = 0; i < gap; i++) begin
			tick();
			s_valid = 1'b0;
		end
		tick();
		s_valid         = 1'b1;
		s_data.dividend = dividend;
		s_data.divisor  = divisor;
		s_data.tag      = next_tag;
		// held stable until the next edge sees s_ready
		while (!s_ready) begin
			tick();
		end
		next_tag = next_tag + 8'd1;
	endtask

	task automatic send_random(input int count, input logic gaps);
		logic [dw-1:0] dividend;
		logic [dw-1:0] divisor;
		logic [dw-1:0] shift;
		logic [dw-1:0] gap;
		for (int i = 0; i < count; i++) begin
			dividend = random_word();
			divisor  = random_word();
			shift    = random_word();
			gap      = random_word();
			// narrow divisors give long quotients
			divisor = divisor >> shift[3:0];
			send_op(dividend, divisor, gaps ? int'(gap[1:0]) : 0);
		end
	endtask

	task automatic send_directed();
		send_op(16'd100, 16'd7, 0);
		send_op(16'd65535, 16'd1, 0);
		send_op(16'd0, 16'd5, 0);
		send_op(16'd1, 16'd65535, 0);
		send_op(16'd65535, 16'd65535, 0);
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		tick();
		s_valid = 1'b0;
		while (exp_q.size() > 0 && waited < 2000) begin
			tick();
			waited++;
		end
		bp_on = 1'b0;
		// spare cycles expose duplicated results
		repeat (20) tick();
		if (exp_q.size() != 0) begin
			$display("ERROR at %0t: %0d expected results never came out", $time, exp_q.size());
			errors++;
			exp_q.delete();
		end
	endtask

	task automatic apply_reset();
		@(negedge clk);
		reset   = 1'b1;
		s_valid = 1'b0;
		m_ready = 1'b1;
		bp_on   = 1'b0;
		// whatever was in flight is gone
		exp_q.delete();
		repeat (8) @(negedge clk);
		reset = 1'b0;
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %0d %s: %0d checks, %0d errors", tests, name,
			checks - test_checks, errors - test_errors);
		test_checks = checks;
		test_errors = errors;
	endtask

	// ------------------------------
	// scoreboard
	// ------------------------------

	// sampled 1 ns after the falling edge, both ports are settled
	always begin : monitor
		div_types_pkg::div_result_t expected;
		@(negedge clk);
		#1;
		if (!reset) begin
			if (m_valid && m_ready) begin
				if (exp_q.size() == 0) begin
					$display("ERROR at %0t: result with tag %0h came out with nothing expected",
						$time, m_data.tag);
					errors++;
				end else begin
					expected = exp_q.pop_front();
					check_field("m_data.quotient", 32'(expected.quotient), 32'(m_data.quotient));
					check_field("m_data.remainder", 32'(expected.remainder),
						32'(m_data.remainder));
					check_field("m_data.tag", 32'(expected.tag), 32'(m_data.tag));
				end
			end
			if (s_valid && s_ready) begin
				exp_q.push_back(expected_result(s_data.dividend, s_data.divisor, s_data.tag));
			end
			if (!s_ready && exp_q.size() > 0) begin
				saw_stall = 1'b1;
			end
		end
	end

	initial begin : watchdog
		#(watchdog_cycles * clk_period);
		$display("ERROR: run did not finish within %0d cycles", watchdog_cycles);
		$display("Simulation failed");
		$finish;
	end

	// ------------------------------
	// test sequence
	// ------------------------------

	initial begin
		seed        = 32'hc344;
		clk         = 1'b0;
		reset       = 1'b1;
		s_valid     = 1'b0;
		s_data      = '0;
		m_ready     = 1'b1;
		bp_on       = 1'b0;
		saw_stall   = 1'b0;
		next_tag    = '0;
		errors      = 0;
		checks      = 0;
		tests       = 0;
		test_errors = 0;
		test_checks = 0;
		apply_reset();

		check_field("s_ready", 32'd1, 32'(s_ready));
		check_field("m_valid", 32'd0, 32'(m_valid));
		send_directed();
		drain();
		end_test("directed set");

		send_op(16'd0, 16'd0, 0);
		send_op(16'd1, 16'd0, 0);
		send_op(16'd1234, 16'd0, 0);
		send_op(16'h8000, 16'd0, 0);
		send_op(16'hffff, 16'd0, 0);
		send_op(random_word(), 16'd0, 0);
		drain();
		end_test("divide by zero");

		send_random(500, 1'b0);
		drain();
		end_test("back to back");

		saw_stall = 1'b0;
		bp_on     = 1'b1;
		send_random(500, 1'b0);
		drain();
		if (!saw_stall) begin
			$display("ERROR at %0t: s_ready never fell while results were pending", $time);
			errors++;
		end
		end_test("back-pressure");

		bp_on = 1'b1;
		send_random(300, 1'b1);
		drain();
		end_test("gaps and back-pressure");

		// leave work in flight, then reset
		bp_on = 1'b1;
		send_random(20, 1'b0);
		apply_reset();
		check_field("s_ready", 32'd1, 32'(s_ready));
		for (int i = 0; i < 30; i++) begin
			tick();
			check_field("m_valid", 32'd0, 32'(m_valid));
		end
		send_directed();
		drain();
		end_test("reset in flight");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* project.f */
div_types_pkg.sv
pipe_pkg.sv
pipeline_insert_ff.sv
pipeline_control.sv
div_stage.sv
pipelined_divider.sv
tb_pipelined_divider.sv

/* Makefile */
TOP = tb_pipelined_divider
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
